//--- verilog/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath and register file sizes
`define MIPS_XLEN 32
`define MIPS_NREG 32
`define MIPS_RESET_PC 32'h0000_0000

// primary opcodes
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_J 6'h02
`define MIPS_OP_JAL 6'h03
`define MIPS_OP_BEQ 6'h04
`define MIPS_OP_BNE 6'h05
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_ORI 6'h0d
`define MIPS_OP_LUI 6'h0f
`define MIPS_OP_LW 6'h23
`define MIPS_OP_SW 6'h2b

// funct codes under the R-type opcode
`define MIPS_FN_SLL 6'h00
`define MIPS_FN_JR 6'h08
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND 6'h24
`define MIPS_FN_OR 6'h25
`define MIPS_FN_SLT 6'h2a

`endif

//--- verilog/mips_pkg.sv
package mips_pkg;

`include "mips_cfg.svh"

	// R-type view of an instruction word
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	// I-type view of the same word
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC8
	} wb_sel_e;

	typedef enum logic [1:0] {
		FWD_RF,
		FWD_EXMEM,
		FWD_MEMWB
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic alu_src_imm;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		wb_sel_e wb_sel;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [`MIPS_XLEN-1:0] pc8;
		logic [`MIPS_XLEN-1:0] rs_val;
		logic [`MIPS_XLEN-1:0] rt_val;
		logic [`MIPS_XLEN-1:0] imm;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] dest;
		logic [4:0] shamt;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [`MIPS_XLEN-1:0] pc8;
		logic [`MIPS_XLEN-1:0] alu_res;
		logic [`MIPS_XLEN-1:0] store_val;
		logic [4:0] dest;
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		wb_sel_e wb_sel;
		logic [`MIPS_XLEN-1:0] pc8;
		logic [`MIPS_XLEN-1:0] alu_res;
		logic [`MIPS_XLEN-1:0] load_val;
		logic [4:0] dest;
	} mem_wb_t;

	typedef struct packed {
		logic we;
		logic [4:0] addr;
		logic [`MIPS_XLEN-1:0] data;
	} wb_bus_t;

	// true when a pending write to dst produces source src; r0 never counts
	function automatic logic reg_dep(input logic we, input logic [4:0] dst,
			input logic [4:0] src);
		return we && (dst != 5'd0) && (dst == src);
	endfunction

endpackage

//--- verilog/fetch.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module fetch (
	input logic i_clk,
	input logic i_arst_n,
	input logic [31:0] i_instr,
	input logic i_stall,
	input logic i_redirect,
	input logic [31:0] i_target,

	output logic [31:0] o_pc,
	output logic [31:0] o_if_pc4,
	output mips_pkg::instr_u o_if_instr
);

	logic [31:0] pc_next;

	// stall wins, decode never redirects while stalled anyway
	always_comb begin
		if (i_stall)
			pc_next = o_pc;
		else if (i_redirect)
			pc_next = i_target;
		else
			pc_next = o_pc + 32'd4;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_pc <= `MIPS_RESET_PC;
		end else begin
			o_pc <= pc_next;
		end
	end

	// IF/ID, a zero word is sll r0 and acts as a nop
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_if_instr <= '0;
			o_if_pc4 <= '0;
		end else if (!i_stall) begin
			o_if_instr <= i_instr;
			o_if_pc4 <= o_pc + 32'd4;
		end
	end

endmodule

//--- verilog/regfile.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module regfile (
	input logic i_clk,
	input logic i_arst_n,
	input mips_pkg::wb_bus_t i_wb,
	input logic [4:0] i_ra,
	input logic [4:0] i_rb,

	output logic [31:0] o_da,
	output logic [31:0] o_db
);

	logic [31:0] regs [`MIPS_NREG];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `MIPS_NREG; i++)
				regs[i] <= '0;
		end else if (i_wb.we && i_wb.addr != 5'd0) begin
			regs[i_wb.addr] <= i_wb.data;
		end
	end

	// same-cycle write is visible to the reader
	always_comb begin
		o_da = regs[i_ra];
		if (i_ra == 5'd0)
			o_da = '0;
		else if (i_wb.we && i_wb.addr == i_ra)
			o_da = i_wb.data;
		o_db = regs[i_rb];
		if (i_rb == 5'd0)
			o_db = '0;
		else if (i_wb.we && i_wb.addr == i_rb)
			o_db = i_wb.data;
	end

endmodule

//--- verilog/decode.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module decode (
	input logic i_clk,
	input logic i_arst_n,
	input mips_pkg::instr_u i_instr,
	input logic [31:0] i_pc4,
	input mips_pkg::wb_bus_t i_wb,
	input logic [4:0] i_ex_dest,
	input logic i_ex_load,
	input logic i_ex_regwrite,
	input logic [4:0] i_mem_dest,
	input logic i_mem_load,
	input logic i_mem_regwrite,
	input logic [31:0] i_mem_alures,

	output logic o_stall,
	output logic o_redirect,
	output logic [31:0] o_target,
	output mips_pkg::id_ex_t o_id_ex
);

	import mips_pkg::*;

	ctrl_t ctrl;
	logic [31:0] imm;
	logic [4:0] dest;
	logic uses_rs;
	logic uses_rt;
	logic is_beq;
	logic is_bne;
	logic is_j;
	logic is_jr;
	logic [31:0] rf_a;
	logic [31:0] rf_b;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic taken;
	logic cmp_rs;
	logic cmp_rt;
	logic load_use;
	logic br_hazard;

	regfile u_regfile (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_wb(i_wb),
		.i_ra(i_instr.r.rs),
		.i_rb(i_instr.r.rt),
		.o_da(rf_a),
		.o_db(rf_b)
	);

	always_comb begin
		ctrl = '0;
		imm = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};
		dest = 5'd0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_j = 1'b0;
		is_jr = 1'b0;
		case (i_instr.r.op)
			`MIPS_OP_RTYPE: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				dest = i_instr.r.rd;
				ctrl.reg_write = 1'b1;
				case (i_instr.r.funct)
					`MIPS_FN_ADDU: ctrl.alu_op = ALU_ADD;
					`MIPS_FN_SUBU: ctrl.alu_op = ALU_SUB;
					`MIPS_FN_AND: ctrl.alu_op = ALU_AND;
					`MIPS_FN_OR: ctrl.alu_op = ALU_OR;
					`MIPS_FN_SLT: ctrl.alu_op = ALU_SLT;
					`MIPS_FN_SLL: begin
						ctrl.alu_op = ALU_SLL;
						uses_rs = 1'b0;
					end
					`MIPS_FN_JR: begin
						is_jr = 1'b1;
						uses_rt = 1'b0;
						ctrl.reg_write = 1'b0;
						dest = 5'd0;
					end
					default: begin
						ctrl.reg_write = 1'b0;
						dest = 5'd0;
					end
				endcase
			end
			`MIPS_OP_ADDIU, `MIPS_OP_ORI, `MIPS_OP_LUI, `MIPS_OP_LW: begin
				uses_rs = (i_instr.i.op != `MIPS_OP_LUI);
				dest = i_instr.i.rt;
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				if (i_instr.i.op == `MIPS_OP_ORI) begin
					ctrl.alu_op = ALU_OR;
					imm = {16'h0000, i_instr.i.imm};
				end else if (i_instr.i.op == `MIPS_OP_LUI) begin
					ctrl.alu_op = ALU_LUI;
				end else if (i_instr.i.op == `MIPS_OP_LW) begin
					ctrl.mem_read = 1'b1;
					ctrl.wb_sel = WB_MEM;
				end
			end
			`MIPS_OP_SW: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			`MIPS_OP_BEQ: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				is_beq = 1'b1;
			end
			`MIPS_OP_BNE: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				is_bne = 1'b1;
			end
			`MIPS_OP_J: is_j = 1'b1;
			`MIPS_OP_JAL: begin
				is_j = 1'b1;
				dest = 5'd31;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = WB_PC8;
			end
			default: ;
		endcase
	end

	// compare operands take the EX/MEM result, older values come through the regfile
	assign rs_val = reg_dep(i_mem_regwrite, i_mem_dest, i_instr.r.rs) ? i_mem_alures : rf_a;
	assign rt_val = reg_dep(i_mem_regwrite, i_mem_dest, i_instr.r.rt) ? i_mem_alures : rf_b;

	assign cmp_rs = is_beq | is_bne | is_jr;
	assign cmp_rt = is_beq | is_bne;

	assign load_use = (uses_rs && reg_dep(i_ex_load, i_ex_dest, i_instr.r.rs))
		|| (uses_rt && reg_dep(i_ex_load, i_ex_dest, i_instr.r.rt));

	// compare sources not yet available in decode
	assign br_hazard = (cmp_rs && reg_dep(i_ex_regwrite, i_ex_dest, i_instr.r.rs))
		|| (cmp_rt && reg_dep(i_ex_regwrite, i_ex_dest, i_instr.r.rt))
		|| (cmp_rs && reg_dep(i_mem_load, i_mem_dest, i_instr.r.rs))
		|| (cmp_rt && reg_dep(i_mem_load, i_mem_dest, i_instr.r.rt));

	assign o_stall = load_use | br_hazard;

	assign taken = (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
	assign o_redirect = !o_stall && (taken || is_j || is_jr);

	always_comb begin
		if (is_jr)
			o_target = rs_val;
		else if (is_j)
			o_target = {i_pc4[31:28], i_instr[25:0], 2'b00};
		else
			o_target = i_pc4 + {imm[29:0], 2'b00};
	end

	// ID/EX, zero control makes the bubble
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_id_ex <= '0;
		end else begin
			o_id_ex.ctrl <= o_stall ? '0 : ctrl;
			o_id_ex.pc8 <= i_pc4 + 32'd4;
			o_id_ex.rs_val <= rf_a;
			o_id_ex.rt_val <= rf_b;
			o_id_ex.imm <= imm;
			o_id_ex.rs <= i_instr.r.rs;
			o_id_ex.rt <= i_instr.r.rt;
			o_id_ex.dest <= dest;
			o_id_ex.shamt <= i_instr.r.shamt;
		end
	end

endmodule

//--- verilog/execute.sv
`timescale 1ns/100ps

module execute (
	input logic i_clk,
	input logic i_arst_n,
	input mips_pkg::id_ex_t i_id_ex,
	input mips_pkg::wb_bus_t i_wb,

	output mips_pkg::ex_mem_t o_ex_mem,
	output logic [4:0] o_ex_dest,
	output logic o_ex_load,
	output logic o_ex_regwrite
);

	import mips_pkg::*;

	fwd_sel_e sel_a;
	fwd_sel_e sel_b;
	logic [31:0] op_a;
	logic [31:0] rt_fwd;
	logic [31:0] op_b;
	logic [31:0] alu_out;

	// the nearer producer in EX/MEM wins
	function automatic fwd_sel_e fwd_pick(input logic [4:0] src, input ex_mem_t exm,
			input wb_bus_t wb);
		if (reg_dep(exm.ctrl.reg_write, exm.dest, src))
			return FWD_EXMEM;
		else if (reg_dep(wb.we, wb.addr, src))
			return FWD_MEMWB;
		return FWD_RF;
	endfunction

	function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] rf,
			input logic [31:0] exm, input logic [31:0] wb);
		case (sel)
			FWD_EXMEM: return exm;
			FWD_MEMWB: return wb;
			default: return rf;
		endcase
	endfunction

	assign sel_a = fwd_pick(i_id_ex.rs, o_ex_mem, i_wb);
	assign sel_b = fwd_pick(i_id_ex.rt, o_ex_mem, i_wb);
	assign op_a = fwd_mux(sel_a, i_id_ex.rs_val, o_ex_mem.alu_res, i_wb.data);
	assign rt_fwd = fwd_mux(sel_b, i_id_ex.rt_val, o_ex_mem.alu_res, i_wb.data);
	assign op_b = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : rt_fwd;

	always_comb begin
		case (i_id_ex.ctrl.alu_op)
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR: alu_out = op_a | op_b;
			ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_SLL: alu_out = op_b << i_id_ex.shamt;
			ALU_LUI: alu_out = {op_b[15:0], 16'h0000};
			default: alu_out = op_a + op_b;
		endcase
	end

	// jal carries its link value as the result so forwarding sees it
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ex_mem <= '0;
		end else begin
			o_ex_mem.ctrl <= i_id_ex.ctrl;
			o_ex_mem.pc8 <= i_id_ex.pc8;
			o_ex_mem.alu_res <= (i_id_ex.ctrl.wb_sel == WB_PC8) ? i_id_ex.pc8 : alu_out;
			o_ex_mem.store_val <= rt_fwd;
			o_ex_mem.dest <= i_id_ex.dest;
		end
	end

	assign o_ex_dest = i_id_ex.dest;
	assign o_ex_load = i_id_ex.ctrl.mem_read;
	assign o_ex_regwrite = i_id_ex.ctrl.reg_write;

endmodule

//--- verilog/mem.sv
`timescale 1ns/100ps

module mem (
	input logic i_clk,
	input logic i_arst_n,
	input mips_pkg::ex_mem_t i_ex_mem,
	input logic [31:0] i_rdata,

	output mips_pkg::wb_bus_t o_wb
);

	import mips_pkg::*;

	mem_wb_t mem_wb;

	// load data is sampled in the same cycle the address is driven
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write <= i_ex_mem.ctrl.reg_write;
			mem_wb.wb_sel <= i_ex_mem.ctrl.wb_sel;
			mem_wb.pc8 <= i_ex_mem.pc8;
			mem_wb.alu_res <= i_ex_mem.alu_res;
			mem_wb.load_val <= i_rdata;
			mem_wb.dest <= i_ex_mem.dest;
		end
	end

	always_comb begin
		o_wb.we = mem_wb.reg_write;
		o_wb.addr = mem_wb.dest;
		case (mem_wb.wb_sel)
			WB_MEM: o_wb.data = mem_wb.load_val;
			WB_PC8: o_wb.data = mem_wb.pc8;
			default: o_wb.data = mem_wb.alu_res;
		endcase
	end

endmodule

//--- verilog/core.sv
`timescale 1ns/100ps

module core (
	input logic i_clk,
	input logic i_arst_n,
	input logic [31:0] i_instr,
	input logic [31:0] i_rdata,

	output logic [31:0] o_instr_addr,
	output logic [31:0] o_data_addr,
	output logic [31:0] o_wdata,
	output logic o_mem_write,
	output logic o_mem_read
);

	import mips_pkg::*;

	instr_u if_instr;
	logic [31:0] if_pc4;
	logic stall;
	logic redirect;
	logic [31:0] target;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	wb_bus_t wb;
	logic [4:0] ex_dest;
	logic ex_load;
	logic ex_regwrite;

	fetch u_fetch (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_instr(i_instr),
		.i_stall(stall),
		.i_redirect(redirect),
		.i_target(target),
		.o_pc(o_instr_addr),
		.o_if_pc4(if_pc4),
		.o_if_instr(if_instr)
	);

	decode u_decode (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_instr(if_instr),
		.i_pc4(if_pc4),
		.i_wb(wb),
		.i_ex_dest(ex_dest),
		.i_ex_load(ex_load),
		.i_ex_regwrite(ex_regwrite),
		.i_mem_dest(ex_mem.dest),
		.i_mem_load(ex_mem.ctrl.mem_read),
		.i_mem_regwrite(ex_mem.ctrl.reg_write),
		.i_mem_alures(ex_mem.alu_res),
		.o_stall(stall),
		.o_redirect(redirect),
		.o_target(target),
		.o_id_ex(id_ex)
	);

	execute u_execute (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_id_ex(id_ex),
		.i_wb(wb),
		.o_ex_mem(ex_mem),
		.o_ex_dest(ex_dest),
		.o_ex_load(ex_load),
		.o_ex_regwrite(ex_regwrite)
	);

	mem u_mem (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_ex_mem(ex_mem),
		.i_rdata(i_rdata),
		.o_wb(wb)
	);

	// data port straight from EX/MEM
	assign o_data_addr = ex_mem.alu_res;
	assign o_wdata = ex_mem.store_val;
	assign o_mem_write = ex_mem.ctrl.mem_write;
	assign o_mem_read = ex_mem.ctrl.mem_read;

endmodule

//--- bench/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// 16-bit Fibonacci LFSR with taps 16 14 13 11
logic [15:0] lfsr_state;

function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	logic fb;
	v = '0;
	for (int k = 0; k < n; k++) begin
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		v = {v[30:0], fb};
	end
	return v;
endfunction

// initial data memory word built from every address bit
function automatic logic [31:0] fill_word(input logic [7:0] a);
	return (32'h9e37_79b9 * ({24'd0, a} + 32'd1)) ^ {a, ~a, a, ~a};
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
	instr_u w;
	w.r.op = `MIPS_OP_RTYPE;
	w.r.rs = rs;
	w.r.rt = rt;
	w.r.rd = rd;
	w.r.shamt = sh;
	w.r.funct = fn;
	return w;
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	instr_u w;
	w.i.op = op;
	w.i.rs = rs;
	w.i.rt = rt;
	w.i.imm = imm;
	return w;
endfunction

// jump target given as a word index
function automatic logic [31:0] enc_j(input logic [5:0] op, input int idx);
	return {op, 26'(idx)};
endfunction

task automatic emit(input logic [31:0] w);
	imem[n_instr[7:0]] = w;
	n_instr++;
endtask

// stores go to 0x80..0xf8 and leave 0xfc for the end marker
task automatic emit_store(input logic [4:0] r);
	emit(enc_i(`MIPS_OP_SW, 5'd0, r, 16'(32'h80 + 4 * (store_slot % 31))));
	store_slot++;
endtask

task automatic build_program();
	logic [4:0] d [9];
	logic [4:0] ra;
	logic [4:0] rb;
	logic [4:0] rc;
	logic [15:0] v;
	int base;
	int c;
	lfsr_state = 16'd89;
	n_instr = 0;
	store_slot = 0;
	// dependent ALU chains with nine distinct destinations per round
	for (int round = 0; round < 6; round++) begin
		base = int'(take_bits(3));
		for (int k = 0; k < 9; k++)
			d[k] = 5'(1 + (base + k) % 9);
		emit(enc_i(`MIPS_OP_LUI, 5'd0, d[0], 16'(take_bits(16))));
		emit(enc_i(`MIPS_OP_ORI, d[0], d[1], 16'(take_bits(16))));
		emit(enc_i(`MIPS_OP_ADDIU, d[1], d[2], 16'(take_bits(16))));
		emit(enc_r(`MIPS_FN_ADDU, d[2], d[1], d[3], 5'd0));
		emit(enc_r(`MIPS_FN_SUBU, d[3], d[0], d[4], 5'd0));
		emit(enc_r(`MIPS_FN_AND, d[4], d[3], d[5], 5'd0));
		emit(enc_r(`MIPS_FN_OR, d[5], d[2], d[6], 5'd0));
		emit(enc_r(`MIPS_FN_SLT, d[6], d[4], d[7], 5'd0));
		emit(enc_r(`MIPS_FN_SLL, 5'd0, d[6], d[8], 5'(take_bits(5))));
		for (int k = 8; k >= 0; k--)
			emit_store(d[k]);
	end
	// load-use and a load straight into store data
	for (int round = 0; round < 3; round++) begin
		ra = 5'(1 + take_bits(3));
		rb = 5'(1 + take_bits(3));
		rc = 5'(1 + take_bits(3));
		emit(enc_i(`MIPS_OP_LW, 5'd0, ra, 16'(4 * take_bits(6))));
		emit(enc_r(`MIPS_FN_ADDU, ra, ra, rb, 5'd0));
		emit_store(rb);
		emit(enc_i(`MIPS_OP_LW, 5'd0, rc, 16'(4 * take_bits(6))));
		emit_store(rc);
	end
	// beq not taken, beq taken, bne taken, bne not taken
	for (int k = 0; k < 4; k++) begin
		v = 16'(take_bits(16));
		emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd10, v));
		emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd11, k[0] ? v : (v ^ 16'h0001)));
		emit(enc_i(k < 2 ? `MIPS_OP_BEQ : `MIPS_OP_BNE, 5'd10, 5'd11, 16'd2));
		emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd12, 16'h0111));
		emit(enc_i(`MIPS_OP_ADDIU, 5'd12, 5'd12, 16'h0010));
		emit(enc_i(`MIPS_OP_ADDIU, 5'd12, 5'd12, 16'h0002));
		emit_store(5'd12);
	end
	// j over one word
	c = n_instr;
	emit(enc_j(`MIPS_OP_J, c + 3));
	emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd15, 16'd5));
	emit(enc_i(`MIPS_OP_ADDIU, 5'd15, 5'd15, 16'd100));
	emit(enc_i(`MIPS_OP_ADDIU, 5'd15, 5'd15, 16'd7));
	emit_store(5'd15);
	// jal to a subroutine that returns with jr r31
	c = n_instr;
	emit(enc_j(`MIPS_OP_JAL, c + 7));
	emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd16, 16'(take_bits(16))));
	emit_store(5'd31);
	emit_store(5'd16);
	emit_store(5'd17);
	emit(enc_j(`MIPS_OP_J, c + 10));
	emit(32'h0000_0000);
	emit(enc_i(`MIPS_OP_ADDIU, 5'd16, 5'd17, 16'd3));
	emit(enc_r(`MIPS_FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
	emit(enc_i(`MIPS_OP_ADDIU, 5'd17, 5'd17, 16'd1));
	// jr on a register written just before it
	c = n_instr;
	emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd18, 16'((c + 4) * 4)));
	emit(enc_r(`MIPS_FN_JR, 5'd18, 5'd0, 5'd0, 5'd0));
	emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd19, 16'(take_bits(16))));
	emit(enc_i(`MIPS_OP_ADDIU, 5'd19, 5'd19, 16'd50));
	emit_store(5'd19);
	// r0 stays zero
	emit(enc_i(`MIPS_OP_ADDIU, 5'd0, 5'd0, 16'(take_bits(16))));
	emit_store(5'd0);
	// end marker and a spin loop
	emit(enc_i(`MIPS_OP_ORI, 5'd0, 5'd20, 16'hd00e));
	emit(enc_i(`MIPS_OP_SW, 5'd0, 5'd20, 16'h00fc));
	c = n_instr;
	emit(enc_j(`MIPS_OP_J, c));
	emit(32'h0000_0000);
endtask

// architectural model with one delay slot that records loads and stores
function automatic void run_reference();
	logic [31:0] regs [32];
	logic [31:0] pc;
	logic [31:0] npc;
	logic [31:0] new_npc;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] addr;
	instr_u w;
	logic done;
	int steps;
	for (int k = 0; k < 32; k++)
		regs[k[4:0]] = '0;
	for (int k = 0; k < 256; k++)
		ref_dmem[k[7:0]] = fill_word(k[7:0]);
	pc = `MIPS_RESET_PC;
	npc = pc + 32'd4;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 4096) begin
		w = imem[pc[9:2]];
		a = regs[w.r.rs];
		b = regs[w.r.rt];
		simm = {{16{w.i.imm[15]}}, w.i.imm};
		addr = a + simm;
		new_npc = npc + 32'd4;
		case (w.r.op)
			`MIPS_OP_RTYPE: begin
				case (w.r.funct)
					`MIPS_FN_ADDU: regs[w.r.rd] = a + b;
					`MIPS_FN_SUBU: regs[w.r.rd] = a - b;
					`MIPS_FN_AND: regs[w.r.rd] = a & b;
					`MIPS_FN_OR: regs[w.r.rd] = a | b;
					`MIPS_FN_SLT: regs[w.r.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					`MIPS_FN_SLL: regs[w.r.rd] = b << w.r.shamt;
					`MIPS_FN_JR: new_npc = a;
					default: ;
				endcase
			end
			`MIPS_OP_ADDIU: regs[w.i.rt] = a + simm;
			`MIPS_OP_ORI: regs[w.i.rt] = a | {16'h0000, w.i.imm};
			`MIPS_OP_LUI: regs[w.i.rt] = {w.i.imm, 16'h0000};
			`MIPS_OP_LW: begin
				regs[w.i.rt] = ref_dmem[addr[9:2]];
				exp_load.push_back(addr);
			end
			`MIPS_OP_SW: begin
				ref_dmem[addr[9:2]] = b;
				exp_addr.push_back(addr);
				exp_data.push_back(b);
				done = (addr == 32'h0000_00fc);
			end
			`MIPS_OP_BEQ: if (a == b) new_npc = pc + 32'd4 + (simm << 2);
			`MIPS_OP_BNE: if (a != b) new_npc = pc + 32'd4 + (simm << 2);
			`MIPS_OP_J: new_npc = {npc[31:28], w[25:0], 2'b00};
			`MIPS_OP_JAL: begin
				regs[31] = pc + 32'd8;
				new_npc = {npc[31:28], w[25:0], 2'b00};
			end
			default: ;
		endcase
		regs[0] = '0;
		pc = npc;
		npc = new_npc;
		steps++;
	end
endfunction

`endif

//--- bench/tb_core.sv
`timescale 1ns/100ps
`include "mips_cfg.svh"

module tb_core;

	import mips_pkg::*;

	logic clk;
	logic arst_n;
	logic [31:0] instr;
	logic [31:0] rdata;
	logic [31:0] instr_addr;
	logic [31:0] data_addr;
	logic [31:0] wdata;
	logic mem_write;
	logic mem_read;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] ref_dmem [256];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_load [$];
	int n_instr;
	int store_slot;
	int exp_idx;
	int load_idx;
	int cycle_count;
	int cycle_limit;
	logic all_seen;

	`include "tb_ref.svh"

	core u_core (
		.i_clk(clk),
		.i_arst_n(arst_n),
		.i_instr(instr),
		.i_rdata(rdata),
		.o_instr_addr(instr_addr),
		.o_data_addr(data_addr),
		.o_wdata(wdata),
		.o_mem_write(mem_write),
		.o_mem_read(mem_read)
	);

	// both memories read combinationally by word address
	assign instr = imem[instr_addr[9:2]];
	assign rdata = dmem[data_addr[9:2]];

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (mem_write)
			dmem[data_addr[9:2]] <= wdata;
	end

	task automatic check_addr(input string kind, input int idx,
			input logic [`MIPS_XLEN-1:0] got, input logic [`MIPS_XLEN-1:0] exp,
			output logic ok);
		ok = (got === exp);
		if (!ok)
			$display("ERR at %0d ns: %s %0d went to %h, expected %h",
				$time, kind, idx, got, exp);
	endtask

	task automatic check_word(input int idx, input logic [`MIPS_XLEN-1:0] got,
			input logic [`MIPS_XLEN-1:0] exp, output logic ok);
		ok = (got === exp);
		if (!ok)
			$display("ERR at %0d ns: store %0d wrote %h, expected %h",
				$time, idx, got, exp);
	endtask

	// each load address against the next expected one
	always @(posedge clk) begin
		logic addr_ok;
		if (arst_n && mem_read) begin
			if (load_idx >= exp_load.size()) begin
				$display("a load was seen after the expected loads ended");
				$display("Simulation finished: FAIL");
				$fatal(1, "unexpected load");
			end else begin
				check_addr("load", load_idx, data_addr, exp_load[load_idx], addr_ok);
				if (!addr_ok) begin
					$display("Simulation finished: FAIL");
					$fatal(1, "load address mismatch");
				end else begin
					load_idx = load_idx + 1;
				end
			end
		end
	end

	// compare each store against the next expected one
	always @(posedge clk) begin
		logic addr_ok;
		logic data_ok;
		if (arst_n && mem_write) begin
			if (exp_idx >= exp_addr.size()) begin
				$display("a store was seen after the expected store stream ended");
				$display("Simulation finished: FAIL");
				$fatal(1, "unexpected store");
			end else begin
				check_addr("store", exp_idx, data_addr, exp_addr[exp_idx], addr_ok);
				check_word(exp_idx, wdata, exp_data[exp_idx], data_ok);
				if (!(addr_ok && data_ok)) begin
					$display("Simulation finished: FAIL");
					$fatal(1, "store stream mismatch");
				end else if (exp_idx + 1 == exp_addr.size()
						&& load_idx != exp_load.size()) begin
					$display("the end marker was stored after %0d of %0d loads",
						load_idx, exp_load.size());
					$display("Simulation finished: FAIL");
					$fatal(1, "missing loads");
				end else begin
					exp_idx = exp_idx + 1;
					all_seen = (exp_idx == exp_addr.size());
				end
			end
		end
	end

	initial begin
		arst_n = 1'b0;
		all_seen = 1'b0;
		exp_idx = 0;
		load_idx = 0;
		cycle_count = 0;
		for (int a = 0; a < 256; a++) begin
			imem[a[7:0]] = '0;
			dmem[a[7:0]] = fill_word(a[7:0]);
		end
		build_program();
		run_reference();
		cycle_limit = 4 * n_instr + 100;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		while (!all_seen && cycle_count < cycle_limit) begin
			@(negedge clk);
			cycle_count++;
		end
		if (all_seen) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("the program never finished, %0d of %0d stores seen in %0d cycles",
				exp_idx, exp_addr.size(), cycle_limit);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

endmodule

//--- mips_pipe.f
+incdir+verilog
+incdir+bench
verilog/mips_pkg.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/mem.sv
verilog/core.sv
bench/tb_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module tb_core -f mips_pipe.f -o sim_core
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
